// ==== axi2ahb.f ====
+incdir+source
source/ahb_bus_pkg.sv
source/bridge_pkg.sv
source/bridge_ifs.sv
source/bridge_fsm.sv
source/data_buffer.sv
source/ahb_master_ctrl.sv
source/axi_resp_ctrl.sv
source/axi2ahb.sv
test/axi2ahb_props.sv
test/tb_axi2ahb.sv

// ==== test/tb_axi2ahb.sv ====
// Testbench for the AXI to AHB bridge with a random wait-state AHB slave.
// The slave memory holds 64 beats, indexed by haddr bits 9:4.
`include "axi2ahb_cfg.svh"

module tb_axi2ahb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_BURSTS = 16;
  localparam longint WATCHDOG_NS = N_BURSTS * 40 * 8 * 4;
  localparam logic [2:0] BEAT_SIZE = 3'd4;      // 16-byte beats.

  logic pll_core_cpuclk, pad_cpu_rst_b;
  logic [`AXI2AHB_ID_W-1:0] awid, arid, bid, rid;
  logic [`AXI2AHB_ADDR_W-1:0] awaddr, araddr, haddr;
  logic [`AXI2AHB_LEN_W-1:0] awlen, arlen;
  logic [2:0] awsize, arsize, hburst, hsize;
  logic [1:0] awburst, arburst, bresp, rresp, htrans, hresp;
  logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rlast, rvalid, rready, hwrite, hready;
  logic [`AXI2AHB_DATA_W-1:0] wdata, rdata, hwdata, hrdata;

  int seed = 32'ha7b9ba5d;
  int err_cnt = 0;
  logic [127:0] mem [64];
  logic [127:0] shadow [64];                    // expected memory contents.
  logic [39:0] cur_base;
  int cur_len, err_beat = -1, ap_idx = 0, dp_idx = 0;
  logic [1:0] cur_burst;
  logic dp_valid = 1'b0, dp_write = 1'b0;
  logic [39:0] dp_addr = '0;

  axi2ahb axi2ahb_i (.*);
  bind axi2ahb axi2ahb_props props_i (.*);

  initial
  begin
    pll_core_cpuclk = 1'b0;
    forever #4 pll_core_cpuclk = ~pll_core_cpuclk;
  end

  initial
  begin
    #(WATCHDOG_NS * 1ns);
    $display("watchdog expired, the bridge stopped responding");
    $display("TB FAILED");
    $finish;
  end

  task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
    assert (act === exp)
    else
    begin
      err_cnt++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic logic [39:0] exp_addr(input logic [39:0] base, input int len, input int n);
    logic [39:0] a;
    a = base;
    case (len)
      1: a[4] = base[4] ^ n[0];
      3: a[5:4] = base[5:4] + n[1:0];
      7: a[6:4] = base[6:4] + n[2:0];
      default: a = base;
    endcase
    return a;
  endfunction

  function automatic logic [2:0] exp_hburst(input logic [1:0] burst, input int len);
    if (burst == 2'b01 && len == 3)
      return 3'b011;
    if (burst == 2'b01 && len == 7)
      return 3'b101;
    if (burst == 2'b10 && len == 3)
      return 3'b010;
    if (burst == 2'b10 && len == 7)
      return 3'b100;
    return 3'b001;
  endfunction

  function automatic logic [39:0] make_addr(input int blk, input int beat);
    return 40'hA5_1234_5000 | (blk << 7) | (beat << 4) | 40'h9;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // AHB slave model
  always @(posedge pll_core_cpuclk)
  begin
    if (pad_cpu_rst_b && hready)
    begin
      if (dp_valid && dp_write && hresp == 2'b00)
        mem[dp_addr[9:4]] = hwdata;
      if (htrans == 2'b10)
      begin
        ap_idx = 0;
        check_val("t2 hburst", exp_hburst(cur_burst, cur_len), hburst);
      end
      else if (htrans == 2'b11)
        ap_idx++;
      if (htrans[1])
      begin
        check_val("t3 haddr", exp_addr(cur_base, cur_len, ap_idx), haddr);
        check_val("hsize", BEAT_SIZE, hsize);
      end
      dp_valid = htrans[1];
      dp_write = hwrite;
      dp_addr = haddr;
      dp_idx = ap_idx;
    end
    #1;
    hready = ($random(seed) & 3) != 0;
    hresp = (dp_valid && dp_idx == err_beat && hready) ? 2'b10 : 2'b00;
    hrdata = mem[dp_addr[9:4]];
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // AXI master tasks
  task automatic axi_write(input string name, input logic [39:0] base, input int len,
                           input logic [1:0] burst, input logic [7:0] id, input int ebeat);
    logic [127:0] d;
    logic [39:0] a;
    logic [7:0] got_bid;
    logic [1:0] got_bresp;
    logic done;
    cur_base = base;
    cur_len = len;
    cur_burst = burst;
    err_beat = ebeat;
    @(posedge pll_core_cpuclk);
    #1;
    awid = id;
    awaddr = base;
    awlen = len;
    awburst = burst;
    awsize = BEAT_SIZE;
    awvalid = 1'b1;
    do @(posedge pll_core_cpuclk); while (!awready);
    #1;
    awvalid = 1'b0;
    awsize = 3'd0;
    for (int n = 0; n <= len; n++)
    begin
      d = {$random(seed), $random(seed), $random(seed), $random(seed)};
      wdata = d;
      wlast = (n == len);
      wvalid = 1'b1;
      do @(posedge pll_core_cpuclk); while (!wready);
      #1;
      a = exp_addr(base, len, n);
      shadow[a[9:4]] = d;
    end
    wvalid = 1'b0;
    wlast = 1'b0;
    done = 1'b0;
    while (!done)
    begin
      bready = $random(seed);                   // random back-pressure on B.
      @(posedge pll_core_cpuclk);
      done = bvalid && bready;
      got_bid = bid;
      got_bresp = bresp;
      #1;
    end
    bready = 1'b0;
    check_val({name, " bid"}, id, got_bid);
    check_val({name, " bresp"}, (ebeat >= 0) ? 2'b10 : 2'b00, got_bresp);
  endtask

  task automatic axi_read(input string name, input logic [39:0] base, input int len,
                          input logic [1:0] burst, input logic [7:0] id, input int ebeat);
    logic [39:0] a;
    int n;
    cur_base = base;
    cur_len = len;
    cur_burst = burst;
    err_beat = ebeat;
    @(posedge pll_core_cpuclk);
    #1;
    arid = id;
    araddr = base;
    arlen = len;
    arburst = burst;
    arsize = BEAT_SIZE;
    arvalid = 1'b1;
    do @(posedge pll_core_cpuclk); while (!arready);
    #1;
    arvalid = 1'b0;
    arsize = 3'd0;
    n = 0;
    while (n <= len)
    begin
      rready = $random(seed);
      @(posedge pll_core_cpuclk);
      if (rvalid && rready)
      begin
        a = exp_addr(base, len, n);
        check_val({name, " rdata"}, shadow[a[9:4]], rdata);
        check_val({name, " rresp"}, (n == ebeat) ? 2'b10 : 2'b00, rresp);
        check_val({name, " rlast"}, n == len, rlast);
        check_val({name, " rid"}, id, rid);
        n++;
      end
      #1;
    end
    rready = 1'b0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // test sequence
  initial
  begin
    {awid, arid, awaddr, araddr, awlen, arlen, awburst, arburst} = '0;
    {awvalid, wvalid, wlast, bready, arvalid, rready} = '0;
    awsize = 3'd0;                              // idle sizes differ from the beat size.
    arsize = 3'd0;
    wdata = '0;
    hready = 1'b1;
    hresp = 2'b00;
    hrdata = '0;
    for (int i = 0; i < 64; i++)
    begin
      mem[i] = {4{32'hC0DE0000 + i * 32'h00010001}};
      shadow[i] = mem[i];
    end
    pad_cpu_rst_b = 1'b0;
    repeat (4) @(posedge pll_core_cpuclk);
    #1;
    pad_cpu_rst_b = 1'b1;

    axi_write("t1 len0", make_addr(0, 5), 0, 2'b01, 8'h11, -1);
    axi_read("t1 len0", make_addr(0, 5), 0, 2'b01, 8'h21, -1);
    axi_write("t1 len3", make_addr(1, 2), 3, 2'b01, 8'h12, -1);
    axi_read("t1 len3", make_addr(1, 2), 3, 2'b01, 8'h22, -1);
    axi_write("t1 len7", make_addr(2, 6), 7, 2'b01, 8'h13, -1);
    axi_read("t1 len7", make_addr(2, 6), 7, 2'b01, 8'h23, -1);
    axi_write("t3 wrap4", make_addr(3, 3), 3, 2'b10, 8'h14, -1);
    axi_read("t3 wrap4", make_addr(3, 3), 3, 2'b10, 8'h24, -1);
    axi_write("t3 wrap8", make_addr(4, 1), 7, 2'b10, 8'h15, -1);
    axi_read("t3 wrap8", make_addr(4, 1), 7, 2'b10, 8'h25, -1);
    axi_write("t3 len1", make_addr(5, 7), 1, 2'b10, 8'h16, -1);
    axi_read("t3 len1", make_addr(5, 7), 1, 2'b10, 8'h26, -1);
    axi_write("t2 fixed", make_addr(6, 4), 2, 2'b00, 8'h17, -1);
    axi_read("t2 fixed", make_addr(6, 4), 2, 2'b00, 8'h27, -1);
    axi_write("t4 wr err", make_addr(7, 0), 3, 2'b01, 8'h18, 1);
    axi_read("t4 rd err", make_addr(1, 2), 3, 2'b01, 8'h28, 2);

    repeat (5) @(posedge pll_core_cpuclk);
    $display("summary: %0d testbench errors, %0d assertion errors",
             err_cnt, axi2ahb_i.props_i.fail_cnt);
    if (err_cnt == 0 && axi2ahb_i.props_i.fail_cnt == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// ==== test/axi2ahb_props.sv ====
// Concurrent checks on the AHB and AXI outputs, bound into the bridge top level.
// Checks start at the first clock edge, so reset must be low from time zero.
`include "axi2ahb_cfg.svh"

module axi2ahb_props
(
  input logic                        pll_core_cpuclk,
  input logic                        pad_cpu_rst_b,
  input logic [`AXI2AHB_ADDR_W-1:0]  haddr,
  input logic [1:0]                  htrans,
  input logic                        hready,
  input logic [1:0]                  hresp,
  input logic                        hwrite,
  input logic                        wready,
  input logic                        bvalid,
  input logic                        bready,
  input logic [1:0]                  bresp,
  input logic                        rvalid,
  input logic                        rready,
  input logic [`AXI2AHB_DATA_W-1:0]  rdata,
  input logic [1:0]                  rresp,
  input logic                        rlast
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;

  // ~~~~~~~~~~~~~~~~~~~~
  // reset
  a_reset_idle: assert property (@(posedge pll_core_cpuclk)
    !pad_cpu_rst_b || $rose(pad_cpu_rst_b) |-> htrans == 2'b00 && !wready && !bvalid && !rvalid)
  else
  begin
    fail_cnt++;
    $error("outputs not idle during or just after reset");
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // back-pressure
  a_ahb_wait: assert property (@(posedge pll_core_cpuclk) disable iff (!pad_cpu_rst_b)
    htrans != 2'b00 && !hready |=> $stable(haddr) && $stable(htrans))
  else
  begin
    fail_cnt++;
    $error("haddr or htrans moved during an AHB wait state");
  end

  a_r_hold: assert property (@(posedge pll_core_cpuclk) disable iff (!pad_cpu_rst_b)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp) && $stable(rlast))
  else
  begin
    fail_cnt++;
    $error("R channel changed while rready was low");
  end

  a_b_hold: assert property (@(posedge pll_core_cpuclk) disable iff (!pad_cpu_rst_b)
    bvalid && !bready |=> bvalid && $stable(bresp))
  else
  begin
    fail_cnt++;
    $error("B channel changed while bready was low");
  end

  // a failed write beat stops the burst at once.
  a_wr_err: assert property (@(posedge pll_core_cpuclk) disable iff (!pad_cpu_rst_b)
    hwrite && hready && hresp != 2'b00 |=> htrans == 2'b00 && bresp == 2'b10)
  else
  begin
    fail_cnt++;
    $error("write error did not end the burst with SLVERR");
  end

endmodule

// ==== source/axi2ahb.sv ====
// Store-and-forward bridge from an AXI slave port to an AHB master port.
// One transaction at a time, bursts of at most eight 16-byte beats.
// No arbitration, locking, protection or write strobes are supported.
`include "axi2ahb_cfg.svh"

module axi2ahb
  import ahb_bus_pkg::*, bridge_pkg::*;
(
  input  logic                        pll_core_cpuclk,
  input  logic                        pad_cpu_rst_b,
  input  logic [`AXI2AHB_ID_W-1:0]    awid,
  input  logic [`AXI2AHB_ADDR_W-1:0]  awaddr,
  input  logic [`AXI2AHB_LEN_W-1:0]   awlen,
  input  logic [2:0]                  awsize,
  input  logic [1:0]                  awburst,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`AXI2AHB_DATA_W-1:0]  wdata,
  input  logic                        wlast,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [`AXI2AHB_ID_W-1:0]    bid,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [`AXI2AHB_ID_W-1:0]    arid,
  input  logic [`AXI2AHB_ADDR_W-1:0]  araddr,
  input  logic [`AXI2AHB_LEN_W-1:0]   arlen,
  input  logic [2:0]                  arsize,
  input  logic [1:0]                  arburst,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [`AXI2AHB_ID_W-1:0]    rid,
  output logic [`AXI2AHB_DATA_W-1:0]  rdata,
  output logic [1:0]                  rresp,
  output logic                        rlast,
  output logic                        rvalid,
  input  logic                        rready,
  output logic [`AXI2AHB_ADDR_W-1:0]  haddr,
  output logic [1:0]                  htrans,
  output logic [2:0]                  hburst,
  output logic [2:0]                  hsize,
  output logic                        hwrite,
  output logic [`AXI2AHB_DATA_W-1:0]  hwdata,
  input  logic [`AXI2AHB_DATA_W-1:0]  hrdata,
  input  logic                        hready,
  input  logic [1:0]                  hresp
);

  bridge_state_e state;

  buf_if db_if_i ();
  seq_if seq_if_i ();

  bridge_fsm bridge_fsm_i (
    .pll_core_cpuclk, .pad_cpu_rst_b, .awvalid, .arvalid, .wvalid, .wlast,
    .bready, .rready, .hready, .hresp, .hwrite, .awlen, .arlen, .wdata, .hrdata,
    .db(db_if_i.fsm), .seq(seq_if_i.fsm), .state
  );

  data_buffer data_buffer_i (
    .pll_core_cpuclk, .pad_cpu_rst_b, .db(db_if_i.store)
  );

  ahb_master_ctrl ahb_master_ctrl_i (
    .pll_core_cpuclk, .pad_cpu_rst_b, .hready, .awaddr, .araddr,
    .awburst(axi_burst_e'(awburst)), .arburst(axi_burst_e'(arburst)),
    .awlen, .arlen, .awsize, .arsize, .seq(seq_if_i.ahb),
    .haddr, .htrans, .hburst, .hsize, .hwrite
  );

  axi_resp_ctrl axi_resp_ctrl_i (
    .pll_core_cpuclk, .pad_cpu_rst_b, .state, .awvalid, .arvalid, .awid, .arid,
    .bready, .hready, .ahb_err(seq_if_i.ahb_err), .empty(db_if_i.empty),
    .awready, .arready, .wready, .bid, .bresp, .bvalid, .rid, .rvalid, .rlast
  );

  // the buffer output register serves both directions.
  assign hwdata = db_if_i.rdata;
  assign rdata  = db_if_i.rdata;
  assign rresp  = db_if_i.rerr ? RESP_SLVERR : RESP_OKAY;

endmodule

// ==== source/axi_resp_ctrl.sv ====
// AXI handshake and response side. Ids are latched when the request is accepted.
// bresp reports SLVERR if any AHB write beat failed.
`include "axi2ahb_cfg.svh"

module axi_resp_ctrl
  import ahb_bus_pkg::*, bridge_pkg::*;
(
  input  logic                      pll_core_cpuclk,
  input  logic                      pad_cpu_rst_b,
  input  bridge_state_e             state,
  input  logic                      awvalid,
  input  logic                      arvalid,
  input  logic [`AXI2AHB_ID_W-1:0]  awid,
  input  logic [`AXI2AHB_ID_W-1:0]  arid,
  input  logic                      bready,
  input  logic                      hready,
  input  logic                      ahb_err,
  input  logic                      empty,
  output logic                      awready,
  output logic                      arready,
  output logic                      wready,
  output logic [`AXI2AHB_ID_W-1:0]  bid,
  output resp_t                     bresp,
  output logic                      bvalid,
  output logic [`AXI2AHB_ID_W-1:0]  rid,
  output logic                      rvalid,
  output logic                      rlast
);

  assign awready = (state == ST_IDLE) && awvalid;
  assign arready = (state == ST_IDLE) && arvalid && !awvalid;
  assign wready  = (state == ST_AXI_WDATA);
  assign bvalid  = (state == ST_AXI_BRESP);
  assign rvalid  = (state == ST_AXI_RDATA);
  assign rlast   = rvalid && empty;             // the final beat is already in rdata.

  always_ff @(posedge pll_core_cpuclk)
  begin
    if (awready)
      bid <= awid;
    if (arready)
      rid <= arid;
  end

  always_ff @(posedge pll_core_cpuclk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      bresp <= RESP_OKAY;
    else if ((state == ST_AHB_WRITE || state == ST_AHB_WLAST) && hready)
      bresp <= ahb_err ? RESP_SLVERR : RESP_OKAY;
    else if (state == ST_AXI_BRESP && !bready)
      bresp <= bresp;
    else
      bresp <= RESP_OKAY;
  end

endmodule

// ==== source/ahb_master_ctrl.sv ====
// AHB address phase: captures the request and steps haddr through the beat field.
// The address wraps in bits 6:4 for len 1, 3 and 7 whatever the AXI burst type.
// A write error drops htrans to IDLE and abandons the rest of the burst.
`include "axi2ahb_cfg.svh"

module ahb_master_ctrl
  import ahb_bus_pkg::*, bridge_pkg::*;
(
  input  logic                        pll_core_cpuclk,
  input  logic                        pad_cpu_rst_b,
  input  logic                        hready,
  input  logic [`AXI2AHB_ADDR_W-1:0]  awaddr,
  input  logic [`AXI2AHB_ADDR_W-1:0]  araddr,
  input  axi_burst_e                  awburst,
  input  axi_burst_e                  arburst,
  input  logic [`AXI2AHB_LEN_W-1:0]   awlen,
  input  logic [`AXI2AHB_LEN_W-1:0]   arlen,
  input  logic [2:0]                  awsize,
  input  logic [2:0]                  arsize,
  seq_if.ahb                          seq,
  output logic [`AXI2AHB_ADDR_W-1:0]  haddr,
  output htrans_e                     htrans,
  output hburst_e                     hburst,
  output logic [2:0]                  hsize,
  output logic                        hwrite
);

  haddr_u                     addr_q;
  haddr_u                     addr_nxt;
  logic [`AXI2AHB_LEN_W-1:0]  len_q;
  logic [`AXI2AHB_LEN_W-1:0]  sel_len;
  axi_burst_e                 sel_burst;
  hburst_e                    pre_hburst;
  logic                       step;
  logic                       wr_err;

  assign sel_len   = seq.is_write ? awlen : arlen;
  assign sel_burst = seq.is_write ? awburst : arburst;
  assign step      = seq.seq_phase && hready && !seq.last;
  assign wr_err    = hwrite && seq.seq_phase && seq.ahb_err;
  assign haddr     = addr_q.flat;

  always_comb
  begin
    pre_hburst = HBURST_INCR;                  // undefined length for anything else.
    if (sel_burst == AXI_INCR && sel_len == 'd3)
      pre_hburst = HBURST_INCR4;
    else if (sel_burst == AXI_INCR && sel_len == 'd7)
      pre_hburst = HBURST_INCR8;
    else if (sel_burst == AXI_WRAP && sel_len == 'd3)
      pre_hburst = HBURST_WRAP4;
    else if (sel_burst == AXI_WRAP && sel_len == 'd7)
      pre_hburst = HBURST_WRAP8;
  end

  always_comb
  begin
    addr_nxt = addr_q;
    case (len_q)
      'd1: addr_nxt.f.beat[0]   = ~addr_q.f.beat[0];
      'd3: addr_nxt.f.beat[1:0] = addr_q.f.beat[1:0] + 2'd1;
      'd7: addr_nxt.f.beat      = addr_q.f.beat + 3'd1;
      default: addr_nxt = addr_q;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // address phase registers
  always_ff @(posedge pll_core_cpuclk)
  begin
    if (seq.req_vld)
    begin
      addr_q.flat <= seq.is_write ? awaddr : araddr;
      hsize       <= seq.is_write ? awsize : arsize;
      hburst      <= pre_hburst;
      len_q       <= sel_len;
    end
    else if (step)
      addr_q <= addr_nxt;
  end

  always_ff @(posedge pll_core_cpuclk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      hwrite <= 1'b0;
      htrans <= HTRANS_IDLE;
    end
    else
    begin
      if (seq.req_vld)
        hwrite <= seq.is_write;
      if (seq.start)
        htrans <= HTRANS_NONSEQ;
      else if (wr_err)
        htrans <= HTRANS_IDLE;
      else if (step)
        htrans <= HTRANS_SEQ;
      else if (seq.seq_phase && !hready)
        htrans <= htrans;                      // wait states freeze the transfer.
      else
        htrans <= HTRANS_IDLE;
    end
  end

endmodule

// ==== source/data_buffer.sv ====
// Eight-entry beat store shared by both directions.
// The pointers carry one extra bit so that a full buffer is not seen as empty.
// The output register feeds both hwdata and rdata.
`include "axi2ahb_cfg.svh"

module data_buffer
(
  input  logic  pll_core_cpuclk,
  input  logic  pad_cpu_rst_b,
  buf_if.store  db
);

  logic [`AXI2AHB_DATA_W-1:0]   entry_data [`AXI2AHB_DB_DEPTH];
  logic [`AXI2AHB_DB_DEPTH-1:0] entry_err;
  logic [`AXI2AHB_DB_PTR_W:0]   wptr;
  logic [`AXI2AHB_DB_PTR_W:0]   rptr;

  assign db.empty = (wptr == rptr);

  always_ff @(posedge pll_core_cpuclk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      wptr <= '0;
      rptr <= '0;
    end
    else if (db.clr)
    begin
      wptr <= '0;
      rptr <= '0;
    end
    else
    begin
      if (db.wr)
        wptr <= wptr + 1'b1;
      if (db.rd)
        rptr <= rptr + 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // storage and output register
  always_ff @(posedge pll_core_cpuclk)
  begin
    if (db.wr)
    begin
      entry_data[wptr[`AXI2AHB_DB_PTR_W-1:0]] <= db.wdata;
      entry_err[wptr[`AXI2AHB_DB_PTR_W-1:0]]  <= db.werr;
    end
    if (db.rd)
    begin
      db.rdata <= entry_data[rptr[`AXI2AHB_DB_PTR_W-1:0]];
      db.rerr  <= entry_err[rptr[`AXI2AHB_DB_PTR_W-1:0]];
    end
  end

endmodule

// ==== source/bridge_fsm.sv ====
// Transaction sequencer with one transaction in flight. A write wins over a read in idle.
// The first AHB read cycle is address only, so its data is not stored.
// An AHB error is taken as hresp nonzero with hready high.
`include "axi2ahb_cfg.svh"

module bridge_fsm
  import ahb_bus_pkg::*, bridge_pkg::*;
(
  input  logic                        pll_core_cpuclk,
  input  logic                        pad_cpu_rst_b,
  input  logic                        awvalid,
  input  logic                        arvalid,
  input  logic                        wvalid,
  input  logic                        wlast,
  input  logic                        bready,
  input  logic                        rready,
  input  logic                        hready,
  input  resp_t                       hresp,
  input  logic                        hwrite,
  input  logic [`AXI2AHB_LEN_W-1:0]   awlen,
  input  logic [`AXI2AHB_LEN_W-1:0]   arlen,
  input  logic [`AXI2AHB_DATA_W-1:0]  wdata,
  input  logic [`AXI2AHB_DATA_W-1:0]  hrdata,
  buf_if.fsm                          db,
  seq_if.fsm                          seq,
  output bridge_state_e               state
);

  bridge_state_e              nxt_state;
  logic [`AXI2AHB_LEN_W-1:0]  wr_cnt;
  logic [`AXI2AHB_LEN_W-1:0]  rd_cnt;
  logic                       wr_cnt_zero;
  logic                       rd_cnt_zero;
  logic                       first_rd;
  logic                       ahb_err;
  logic                       rd_req;

  assign ahb_err     = hready && (hresp != RESP_OKAY);
  assign wr_cnt_zero = (wr_cnt == '0);
  assign rd_cnt_zero = (rd_cnt == '0);
  assign rd_req      = (state == ST_IDLE) && arvalid && !awvalid;

  // ~~~~~~~~~~~~~~~~~~~~
  // state register
  always_ff @(posedge pll_core_cpuclk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      state <= ST_IDLE;
    else
      state <= nxt_state;
  end

  always_comb
  begin
    nxt_state = state;
    case (state)
      ST_IDLE:
        if (awvalid)
          nxt_state = ST_AXI_WDATA;
        else if (arvalid)
          nxt_state = ST_AHB_READ;
      ST_AXI_WDATA:
        if (wvalid && wlast)
          nxt_state = ST_AHB_WRITE;
      ST_AHB_WRITE:
        if (ahb_err)
          nxt_state = ST_AXI_BRESP;             // the burst ends early on an error.
        else if (wr_cnt_zero && hready)
          nxt_state = ST_AHB_WLAST;
      ST_AHB_WLAST:
        if (hready)
          nxt_state = ST_AXI_BRESP;
      ST_AXI_BRESP:
        if (bready)
          nxt_state = ST_IDLE;
      ST_AHB_READ:
        if (rd_cnt_zero && hready)
          nxt_state = ST_AHB_RLAST;
      ST_AHB_RLAST:
        if (hready)
          nxt_state = ST_DB_PRIME;
      ST_DB_PRIME:
        nxt_state = ST_AXI_RDATA;
      ST_AXI_RDATA:
        if (db.empty && rready)
          nxt_state = ST_IDLE;
      default:
        nxt_state = ST_IDLE;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // beat counters and first read flag
  always_ff @(posedge pll_core_cpuclk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      wr_cnt   <= '0;
      rd_cnt   <= '0;
      first_rd <= 1'b0;
    end
    else
    begin
      if (state == ST_IDLE && awvalid)
        wr_cnt <= awlen;
      else if (state == ST_AHB_WRITE && hready && !wr_cnt_zero)
        wr_cnt <= wr_cnt - 1'b1;
      if (rd_req)
        rd_cnt <= arlen;
      else if (state == ST_AHB_READ && hready && !rd_cnt_zero)
        rd_cnt <= rd_cnt - 1'b1;
      if (rd_req)
        first_rd <= 1'b1;
      else if (state == ST_AHB_READ && hready)
        first_rd <= 1'b0;                       // the address-only phase is over.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // buffer and sequencing strobes
  assign db.clr   = (state == ST_IDLE);
  assign db.wr    = ((state == ST_AHB_READ || state == ST_AHB_RLAST) && hready && !first_rd)
                  || (state == ST_AXI_WDATA && wvalid);
  assign db.rd    = (state == ST_AHB_WRITE && hready)
                  || (state == ST_AXI_RDATA && rready)
                  || (state == ST_DB_PRIME);   // loads the first read beat.
  assign db.wdata = hwrite ? wdata : hrdata;
  assign db.werr  = !hwrite && ahb_err;

  assign seq.req_vld   = (state == ST_IDLE) && (awvalid || arvalid);
  assign seq.is_write  = awvalid;
  assign seq.start     = rd_req || (state == ST_AXI_WDATA && wvalid && wlast);
  assign seq.seq_phase = (state == ST_AHB_WRITE) || (state == ST_AHB_READ);
  assign seq.last      = hwrite ? wr_cnt_zero : rd_cnt_zero;
  assign seq.ahb_err   = ahb_err;

endmodule

// ==== source/bridge_ifs.sv ====
// Internal interfaces of the bridge.
// buf_if has no handshake; a strobe acts on every cycle where it is high.
`include "axi2ahb_cfg.svh"

// ~~~~~~~~~~~~~~~~~~~~
// sequencer to data buffer
interface buf_if;
  logic                        clr;
  logic                        wr;
  logic                        rd;
  logic [`AXI2AHB_DATA_W-1:0]  wdata;
  logic                        werr;
  logic [`AXI2AHB_DATA_W-1:0]  rdata;
  logic                        rerr;
  logic                        empty;

  modport fsm   (output clr, wr, rd, wdata, werr, input empty);
  modport store (input clr, wr, rd, wdata, werr, output rdata, rerr, empty);
endinterface

// ~~~~~~~~~~~~~~~~~~~~
// sequencer to AHB address phase
interface seq_if;
  logic req_vld;                 // a request is taken in idle.
  logic is_write;
  logic start;                   // next cycle carries the NONSEQ transfer.
  logic seq_phase;
  logic last;
  logic ahb_err;

  modport fsm (output req_vld, is_write, start, seq_phase, last, ahb_err);
  modport ahb (input req_vld, is_write, start, seq_phase, last, ahb_err);
endinterface

// ==== source/bridge_pkg.sv ====
// Internal types of the bridge: the sequencer states and the AHB address view.
// The beat field covers address bits 6:4, so one beat is 16 bytes wide.
`include "axi2ahb_cfg.svh"

package bridge_pkg;

  // one-hot sequencer states.
  typedef enum logic [8:0] {
    ST_IDLE      = 9'b000000001,
    ST_AXI_WDATA = 9'b000000010,
    ST_AHB_WRITE = 9'b000000100,
    ST_AHB_WLAST = 9'b000001000,
    ST_AXI_BRESP = 9'b000010000,
    ST_AHB_READ  = 9'b000100000,
    ST_AHB_RLAST = 9'b001000000,
    ST_DB_PRIME  = 9'b010000000,
    ST_AXI_RDATA = 9'b100000000
  } bridge_state_e;

  typedef union packed {
    logic [`AXI2AHB_ADDR_W-1:0] flat;         // loaded from the request and driven out.
    struct packed {
      logic [`AXI2AHB_ADDR_W-8:0] upper;
      logic [2:0]                 beat;       // stepped for wrapping bursts.
      logic [3:0]                 offset;
    } f;
  } haddr_u;

endpackage

// ==== source/ahb_bus_pkg.sv ====
// Encodings of the AHB and AXI fields used by the bridge.
// Only the response codes OKAY and SLVERR are produced.
package ahb_bus_pkg;

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    HBURST_INCR  = 3'b001,
    HBURST_WRAP4 = 3'b010,
    HBURST_INCR4 = 3'b011,
    HBURST_WRAP8 = 3'b100,
    HBURST_INCR8 = 3'b101
  } hburst_e;

  typedef enum logic [1:0] {
    AXI_FIXED = 2'b00,
    AXI_INCR  = 2'b01,
    AXI_WRAP  = 2'b10
  } axi_burst_e;

  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

endpackage

// ==== source/axi2ahb_cfg.svh ====
// Widths and buffer depth of the AXI to AHB bridge.
// The data buffer holds one burst of up to eight beats. Longer bursts are not supported.
// The pointer width must be log2 of the buffer depth.
`ifndef AXI2AHB_CFG_SVH
`define AXI2AHB_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~
// bus widths
`define AXI2AHB_ADDR_W    40
`define AXI2AHB_DATA_W    128
`define AXI2AHB_ID_W      8
`define AXI2AHB_LEN_W     8

// ~~~~~~~~~~~~~~~~~~~~
// data buffer
`define AXI2AHB_DB_DEPTH  8
`define AXI2AHB_DB_PTR_W  3

`endif
